/* flist.f */
+incdir+sim
rtl/axis_cfg_pkg.sv
rtl/dsz_fsm_pkg.sv
rtl/stream_fifo.sv
rtl/beat_splitter.sv
rtl/axis_data_downsizer.sv
sim/tb_axis_data_downsizer.sv

/* Makefile */
# Verilator build and run of the AXI4-Stream data downsizer testbench
TOP := tb_axis_data_downsizer

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

# the binary exits non-zero when the testbench stops on $$fatal
test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* sim/tb_tasks.svh */
// -------------------------------------------------------------------------
// testbench helpers for the data downsizer
// scoreboard queues, word driver, beat monitor, compare tasks
// -------------------------------------------------------------------------

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// expected beats in output order
logic [M_DATA_W-1:0] exp_data [$];
logic [ID_W-1:0]     exp_id   [$];
logic [DEST_W-1:0]   exp_dest [$];
logic                exp_last [$];

// output fields from the previous negedge
logic                was_stalled = 1'b0;
logic [M_DATA_W-1:0] held_data;
logic [ID_W-1:0]     held_id;
logic [DEST_W-1:0]   held_dest;
logic                held_last;

// -------------------------------------------------------------------------
// compare tasks per result type
// -------------------------------------------------------------------------

task automatic check_data(input string name, input logic [M_DATA_W-1:0] got,
                          input logic [M_DATA_W-1:0] exp);
  if (got !== exp) stop_run($sformatf("FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
endtask

task automatic check_id(input string name, input logic [ID_W-1:0] got,
                        input logic [ID_W-1:0] exp);
  if (got !== exp) stop_run($sformatf("FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
endtask

task automatic check_dest(input string name, input logic [DEST_W-1:0] got,
                          input logic [DEST_W-1:0] exp);
  if (got !== exp) stop_run($sformatf("FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) stop_run($sformatf("FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
endtask

// one word becomes RATIO beats with the msb slice first and tlast only on slice 0
task automatic add_expected(input logic [ID_W-1:0] tid, input logic [DEST_W-1:0] tdest,
                            input logic tlast, input logic [S_DATA_W-1:0] data);
  int i;
  for (i = RATIO - 1; i >= 0; i--) begin
    exp_data.push_back(data[i*M_DATA_W +: M_DATA_W]);
    exp_id.push_back(tid);
    exp_dest.push_back(tdest);
    exp_last.push_back(tlast && (i == 0));
  end
endtask

task automatic drive_word(input logic [ID_W-1:0] tid, input logic [DEST_W-1:0] tdest,
                          input logic tlast, input logic [S_DATA_W-1:0] data);
  s_axis_tvalid = 1'b1;
  s_axis_tid    = tid;
  s_axis_tdest  = tdest;
  s_axis_tlast  = tlast;
  s_axis_tdata  = data;
endtask

// enter and leave at posedge + DRV_DLY around the accept edge
task automatic push_word(input logic [ID_W-1:0] tid, input logic [DEST_W-1:0] tdest,
                         input logic tlast, input logic [S_DATA_W-1:0] data);
  drive_word(tid, tdest, tlast, data);
  @(negedge m_axis_aclk);
  while (!s_axis_tready) @(negedge m_axis_aclk);  // ready only moves on posedge
  add_expected(tid, tdest, tlast, data);
  @(posedge m_axis_aclk);
  #DRV_DLY;
  s_axis_tvalid = 1'b0;
endtask

task automatic send_random_word();
  push_word(ID_W'($urandom), DEST_W'($urandom), ($urandom % 2) == 1, S_DATA_W'($urandom));
endtask

task automatic wait_drain();
  while (exp_data.size() != 0) @(posedge m_axis_aclk);
  #DRV_DLY;
endtask

// sampled at negedge ahead of the transfer edge
task automatic monitor_beat();
  if (m_axis_arstn && was_stalled) begin  // fields must hold while stalled
    check_flag("m_axis_tvalid", m_axis_tvalid, 1'b1);
    check_data("m_axis_tdata", m_axis_tdata, held_data);
    check_id("m_axis_tid", m_axis_tid, held_id);
    check_dest("m_axis_tdest", m_axis_tdest, held_dest);
    check_flag("m_axis_tlast", m_axis_tlast, held_last);
  end
  if (m_axis_arstn && m_axis_tvalid && m_axis_tready) begin
    if (exp_data.size() == 0) begin
      stop_run("an output beat appeared while no beat was expected");
    end else begin
      check_data("m_axis_tdata", m_axis_tdata, exp_data.pop_front());
      check_id("m_axis_tid", m_axis_tid, exp_id.pop_front());
      check_dest("m_axis_tdest", m_axis_tdest, exp_dest.pop_front());
      check_flag("m_axis_tlast", m_axis_tlast, exp_last.pop_front());
    end
  end
  was_stalled = m_axis_arstn && m_axis_tvalid && !m_axis_tready;
  held_data   = m_axis_tdata;
  held_id     = m_axis_tid;
  held_dest   = m_axis_tdest;
  held_last   = m_axis_tlast;
endtask

`endif

/* sim/tb_axis_data_downsizer.sv */
// -------------------------------------------------------------------------
// testbench for the AXI4-Stream data downsizer
// clock, reset, watchdog, DUT instance and directed tests
// -------------------------------------------------------------------------

module tb_axis_data_downsizer
  import axis_cfg_pkg::*;
();

  localparam int S_DATA_W    = DEF_S_DATA_W;
  localparam int M_DATA_W    = DEF_M_DATA_W;
  localparam int ID_W        = DEF_ID_W;
  localparam int DEST_W      = DEF_DEST_W;
  localparam int FIFO_DEPTH  = DEF_FIFO_DEPTH;
  localparam int RATIO       = S_DATA_W / M_DATA_W;
  localparam int DRV_DLY     = 10;                          // drive skew after posedge
  localparam int N_RANDOM    = 40;
  localparam int TOTAL_WORDS = 2 + 2 * N_RANDOM + FIFO_DEPTH + 1;
  localparam int WATCHDOG_T  = TOTAL_WORDS * (RATIO + 4) * 100 + 200 * 100;

  logic                m_axis_aclk;
  logic                m_axis_arstn;
  logic [ID_W-1:0]     s_axis_tid;
  logic [DEST_W-1:0]   s_axis_tdest;
  logic [S_DATA_W-1:0] s_axis_tdata;
  logic                s_axis_tvalid;
  logic                s_axis_tlast;
  logic                s_axis_tready;
  logic [ID_W-1:0]     m_axis_tid;
  logic [DEST_W-1:0]   m_axis_tdest;
  logic [M_DATA_W-1:0] m_axis_tdata;
  logic                m_axis_tvalid;
  logic                m_axis_tlast;
  logic                m_axis_tready;
  logic                rand_ready;  // sink throttles at random when set

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped on the first error");
  endtask

  `include "tb_tasks.svh"

  axis_data_downsizer i_axis_data_downsizer (
    .m_axis_aclk   (m_axis_aclk),
    .m_axis_arstn  (m_axis_arstn),
    .s_axis_tid    (s_axis_tid),
    .s_axis_tdest  (s_axis_tdest),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tready (s_axis_tready),
    .m_axis_tid    (m_axis_tid),
    .m_axis_tdest  (m_axis_tdest),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready)
  );

  always #50 m_axis_aclk = ~m_axis_aclk;        // period 100

  always @(negedge m_axis_aclk) monitor_beat();

  always @(posedge m_axis_aclk) begin
    #DRV_DLY;
    if (rand_ready) m_axis_tready = 1'($urandom);
  end

  initial begin
    #(WATCHDOG_T);
    stop_run("watchdog expired before the tests finished");
  end

  // -------------------------------------------------------------------------
  // directed tests
  // -------------------------------------------------------------------------

  task automatic test_reset_and_single();
    @(negedge m_axis_aclk);
    check_flag("m_axis_tvalid", m_axis_tvalid, 1'b0);
    check_flag("s_axis_tready", s_axis_tready, 1'b1);
    @(posedge m_axis_aclk);
    #DRV_DLY;
    m_axis_tready = 1'b1;
    push_word(ID_W'(8'h5a), DEST_W'(8'h3c), 1'b1, S_DATA_W'(32'h11223344));
    wait_drain();
  endtask

  task automatic test_no_last();
    push_word(ID_W'(8'ha7), DEST_W'(8'h02), 1'b0, S_DATA_W'(32'hdeadbeef));
    wait_drain();
  endtask

  task automatic test_random_stream(input logic throttle);
    int n;
    rand_ready = throttle;
    for (n = 0; n < N_RANDOM; n++) send_random_word();
    wait_drain();
    rand_ready    = 1'b0;
    m_axis_tready = 1'b1;
  endtask

  // sink stalled, count words until the input side fills up
  task automatic test_backpressure_fill();
    int                  accepted;
    logic                filling;
    logic [ID_W-1:0]     tid;
    logic [DEST_W-1:0]   tdest;
    logic                tlast;
    logic [S_DATA_W-1:0] data;
    accepted      = 0;
    filling       = 1'b1;
    m_axis_tready = 1'b0;
    while (filling) begin
      tid   = ID_W'($urandom);
      tdest = DEST_W'($urandom);
      tlast = ($urandom % 2) == 1;
      data  = S_DATA_W'($urandom);
      drive_word(tid, tdest, tlast, data);
      @(negedge m_axis_aclk);
      if (s_axis_tready) begin
        add_expected(tid, tdest, tlast, data);
        accepted++;
      end else begin
        filling = 1'b0;
      end
      @(posedge m_axis_aclk);
      #DRV_DLY;
    end
    s_axis_tvalid = 1'b0;
    if (accepted != FIFO_DEPTH + 1) begin
      stop_run($sformatf("FAILED s_axis_tready word count 0x%0h expected 0x%0h",
                         accepted, FIFO_DEPTH + 1));
    end
    m_axis_tready = 1'b1;                          // drain everything in order
    wait_drain();
  endtask

  initial begin
    m_axis_aclk   = 1'b0;
    m_axis_arstn  = 1'b0;
    s_axis_tid    = '0;
    s_axis_tdest  = '0;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b0;
    rand_ready    = 1'b0;
    void'($urandom(32'h4e135e5d));
    repeat (2) @(posedge m_axis_aclk);
    #DRV_DLY;
    m_axis_arstn = 1'b1;
    test_reset_and_single();
    test_no_last();
    test_random_stream(1'b0);
    test_random_stream(1'b1);
    test_backpressure_fill();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule : tb_axis_data_downsizer

/* rtl/axis_data_downsizer.sv */
// -------------------------------------------------------------------------
// AXI4-Stream data downsizer, top level
// FIFO for burst absorption, then the beat splitter
// -------------------------------------------------------------------------

module axis_data_downsizer
  import axis_cfg_pkg::*;
#(
  parameter int S_DATA_W   = DEF_S_DATA_W,   // input word width
  parameter int M_DATA_W   = DEF_M_DATA_W,   // output beat width
  parameter int ID_W       = DEF_ID_W,
  parameter int DEST_W     = DEF_DEST_W,
  parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
  input  logic                m_axis_aclk,
  input  logic                m_axis_arstn,
  // input stream
  input  logic [ID_W-1:0]     s_axis_tid,
  input  logic [DEST_W-1:0]   s_axis_tdest,
  input  logic [S_DATA_W-1:0] s_axis_tdata,
  input  logic                s_axis_tvalid,
  input  logic                s_axis_tlast,
  output logic                s_axis_tready,
  // output stream
  output logic [ID_W-1:0]     m_axis_tid,
  output logic [DEST_W-1:0]   m_axis_tdest,
  output logic [M_DATA_W-1:0] m_axis_tdata,
  output logic                m_axis_tvalid,
  output logic                m_axis_tlast,
  input  logic                m_axis_tready
);

  // one FIFO entry carries a whole input transfer
  localparam int ENTRY_W = ID_W + DEST_W + 1 + S_DATA_W;

  logic [ENTRY_W-1:0]  push_data;
  logic [ENTRY_W-1:0]  pop_data;
  logic                pop;
  logic                pop_empty;

  logic [ID_W-1:0]     word_tid;
  logic [DEST_W-1:0]   word_tdest;
  logic                word_tlast;
  logic [S_DATA_W-1:0] word_tdata;

  // entry layout msb to lsb: tid, tdest, tlast, data
  assign push_data = {s_axis_tid, s_axis_tdest, s_axis_tlast, s_axis_tdata};
  assign {word_tid, word_tdest, word_tlast, word_tdata} = pop_data;

  stream_fifo #(
    .ENTRY_W (ENTRY_W),
    .DEPTH   (FIFO_DEPTH)
  ) i_stream_fifo (
    .m_axis_aclk  (m_axis_aclk),
    .m_axis_arstn (m_axis_arstn),
    .push_valid   (s_axis_tvalid),
    .push_data    (push_data),
    .push_ready   (s_axis_tready),  // low only when full
    .pop          (pop),
    .pop_data     (pop_data),
    .pop_empty    (pop_empty)
  );

  beat_splitter #(
    .S_DATA_W (S_DATA_W),
    .M_DATA_W (M_DATA_W),
    .ID_W     (ID_W),
    .DEST_W   (DEST_W)
  ) i_beat_splitter (
    .m_axis_aclk   (m_axis_aclk),
    .m_axis_arstn  (m_axis_arstn),
    .pop_empty     (pop_empty),
    .word_tid      (word_tid),
    .word_tdest    (word_tdest),
    .word_tlast    (word_tlast),
    .word_tdata    (word_tdata),
    .pop           (pop),
    .m_axis_tready (m_axis_tready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tid    (m_axis_tid),
    .m_axis_tdest  (m_axis_tdest),
    .m_axis_tlast  (m_axis_tlast)
  );

endmodule : axis_data_downsizer

/* rtl/beat_splitter.sv */
// -------------------------------------------------------------------------
// word to beat splitter
// holding register, beat FSM, slice index and output mux
// msb slice goes out first, tlast only on the lsb slice
// -------------------------------------------------------------------------

module beat_splitter
  import dsz_fsm_pkg::*;
#(
  parameter int S_DATA_W = 32,  // held word width
  parameter int M_DATA_W = 8,   // beat width
  parameter int ID_W     = 8,
  parameter int DEST_W   = 8
) (
  input  logic                m_axis_aclk,
  input  logic                m_axis_arstn,
  // word side, FIFO head
  input  logic                pop_empty,
  input  logic [ID_W-1:0]     word_tid,
  input  logic [DEST_W-1:0]   word_tdest,
  input  logic                word_tlast,
  input  logic [S_DATA_W-1:0] word_tdata,
  output logic                pop,           // one cycle, only when !pop_empty
  // beat side
  input  logic                m_axis_tready,
  output logic                m_axis_tvalid,
  output logic [M_DATA_W-1:0] m_axis_tdata,
  output logic [ID_W-1:0]     m_axis_tid,
  output logic [DEST_W-1:0]   m_axis_tdest,
  output logic                m_axis_tlast
);

  localparam int RATIO = S_DATA_W / M_DATA_W;  // beats per word, >= 2
  localparam int IDX_W = $clog2(RATIO);

  dsz_state_e state;
  dsz_state_e next_state;

  logic [IDX_W-1:0]    slice_idx;  // RATIO-1 down to 0
  logic                load;       // pop and capture on the same edge

  // holding register, payload only
  logic [S_DATA_W-1:0] hold_tdata;
  logic [ID_W-1:0]     hold_tid;
  logic [DEST_W-1:0]   hold_tdest;
  logic                hold_tlast;

  // -------------------------------------------------------------------------
  // FSM
  // -------------------------------------------------------------------------

  // idle with data, or last beat leaving with another word queued
  assign load = !pop_empty &&
                ((state == ST_IDLE) || (state == ST_SEND_LAST && m_axis_tready));
  assign pop  = load;

  always_comb begin
    next_state = state;
    case (state)
      ST_IDLE: begin
        if (!pop_empty) next_state = ST_SEND_FIRST;
      end
      ST_SEND_FIRST,
      ST_SEND_BODY: begin
        if (m_axis_tready) begin
          // index 1 means the next beat is the lsb slice
          if (slice_idx == IDX_W'(1)) next_state = ST_SEND_LAST;
          else                        next_state = ST_SEND_BODY;
        end
      end
      ST_SEND_LAST: begin
        if (m_axis_tready) begin
          next_state = pop_empty ? ST_IDLE : ST_SEND_FIRST;  // back to back, no bubble
        end
      end
      default: next_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge m_axis_aclk) begin
    if (!m_axis_arstn) begin
      state     <= ST_IDLE;
      slice_idx <= IDX_W'(RATIO - 1);
    end else begin
      state <= next_state;
      if (load) begin
        slice_idx <= IDX_W'(RATIO - 1);  // restart at msb slice
      end else if (m_axis_tvalid && m_axis_tready && state != ST_SEND_LAST) begin
        slice_idx <= slice_idx - 1'b1;
      end
    end
  end

  // capture FIFO head
  always_ff @(posedge m_axis_aclk) begin
    if (load) begin
      hold_tdata <= word_tdata;
      hold_tid   <= word_tid;
      hold_tdest <= word_tdest;
      hold_tlast <= word_tlast;
    end
  end

  // -------------------------------------------------------------------------
  // beat outputs, all from registers so they hold under back-pressure
  // -------------------------------------------------------------------------

  assign m_axis_tvalid = (state != ST_IDLE);
  assign m_axis_tdata  = hold_tdata[int'(slice_idx) * M_DATA_W +: M_DATA_W];
  assign m_axis_tid    = hold_tid;
  assign m_axis_tdest  = hold_tdest;
  assign m_axis_tlast  = hold_tlast & (state == ST_SEND_LAST);

endmodule : beat_splitter

/* rtl/stream_fifo.sv */
// -------------------------------------------------------------------------
// single-clock first-word-fall-through FIFO
// circular buffer, pointers with a wrap bit for full/empty
// -------------------------------------------------------------------------

module stream_fifo #(
  parameter int ENTRY_W = 49,  // packed stream word
  parameter int DEPTH   = 16   // entry count of 1 or more
) (
  input  logic               m_axis_aclk,
  input  logic               m_axis_arstn,  // sync active low
  // push side
  input  logic               push_valid,
  input  logic [ENTRY_W-1:0] push_data,
  output logic               push_ready,    // high while not full
  // pop side
  input  logic               pop,           // caller only pops when not empty
  output logic [ENTRY_W-1:0] pop_data,      // head entry while !pop_empty
  output logic               pop_empty
);

  // slot index bits with a floor of 1
  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // -------------------------------------------------------------------------
  // storage and pointers
  // -------------------------------------------------------------------------

  logic [ENTRY_W-1:0] mem [DEPTH];  // entry storage

  // pointer msb is the wrap bit above the slot index
  logic [ADDR_W:0] wr_ptr;
  logic [ADDR_W:0] rd_ptr;

  logic full;
  logic empty;
  logic push_fire;

  // advance a pointer and flip the wrap bit past slot DEPTH-1
  // also correct for depths that are not a power of two
  function automatic logic [ADDR_W:0] ptr_inc(input logic [ADDR_W:0] ptr);
    logic [ADDR_W:0] res;
    if (ptr[ADDR_W-1:0] == ADDR_W'(DEPTH - 1)) begin
      res = {~ptr[ADDR_W], {ADDR_W{1'b0}}};
    end else begin
      res = ptr + 1'b1;
    end
    return res;
  endfunction

  // same slot, same lap -> empty; same slot, other lap -> full
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]) &&
                 (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]);

  assign push_ready = ~full;
  assign push_fire  = push_valid & push_ready;

  // -------------------------------------------------------------------------
  // pointer update
  // -------------------------------------------------------------------------

  always_ff @(posedge m_axis_aclk) begin
    if (!m_axis_arstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);  // empty is not re-checked here
      end
    end
  end

  // write port
  always_ff @(posedge m_axis_aclk) begin
    if (push_fire) begin
      mem[wr_ptr[ADDR_W-1:0]] <= push_data;
    end
  end

  // fall-through read shows the head right after the push edge
  assign pop_data  = mem[rd_ptr[ADDR_W-1:0]];
  assign pop_empty = empty;

endmodule : stream_fifo

/* rtl/dsz_fsm_pkg.sv */
// -------------------------------------------------------------------------
// splitter control encodings
// -------------------------------------------------------------------------

package dsz_fsm_pkg;

  // beat sequencing of one held word
  // SEND_BODY only shows up when the ratio is above 2
  typedef enum logic [1:0] {
    ST_IDLE       = 2'b00,  // nothing held, waiting on the FIFO
    ST_SEND_FIRST = 2'b01,  // msb slice on the bus
    ST_SEND_BODY  = 2'b10,  // middle slices
    ST_SEND_LAST  = 2'b11   // lsb slice, carries tlast
  } dsz_state_e;

endpackage : dsz_fsm_pkg

/* rtl/axis_cfg_pkg.sv */
// -------------------------------------------------------------------------
// stream format defaults for the data downsizer
// widths of data, tid and tdest on both sides, FIFO depth
// -------------------------------------------------------------------------

package axis_cfg_pkg;

  // input word width, split into DEF_S_DATA_W / DEF_M_DATA_W beats
  localparam int DEF_S_DATA_W = 32;

  // output beat width, ratio must come out at 2 or more
  localparam int DEF_M_DATA_W = 8;

  // sideband fields, copied unchanged onto every beat
  localparam int DEF_ID_W     = 8;  // tid
  localparam int DEF_DEST_W   = 8;  // tdest

  // words buffered ahead of the splitter
  // one more word sits in the splitter holding register
  localparam int DEF_FIFO_DEPTH = 16;

endpackage : axis_cfg_pkg
